/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module csr_unit_tb \
		-f filelist.f -o csr_unit_sim
	./obj_dir/csr_unit_sim | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* include/csr_tb_tasks.svh */
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

// inputs change a little after the rising edge
task automatic next_cycle();
    @(posedge clk);
    #2;
endtask

task automatic clear_inputs();
    req = '0;
    trap = '0;
    stall = 1'b0;
    flush = 1'b0;
    instr_retired = 1'b0;
    writeback_flush = 1'b0;
endtask

task automatic check_word(input string name, input csr_word_t expected,
                          input csr_word_t actual);
    checks++;
    if (actual !== expected) begin
        $display("Mismatch at %0t ns: %s expected 0x%08h actual 0x%08h",
                 $time, name, expected, actual);
        mismatches++;
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
        $display("Mismatch at %0t ns: %s expected %b actual %b",
                 $time, name, expected, actual);
        mismatches++;
    end
endtask

task automatic check_count(input string name, input logic [counter_w-1:0] expected,
                           input logic [counter_w-1:0] actual);
    checks++;
    if (actual !== expected) begin
        $display("Mismatch at %0t ns: %s expected %0d actual %0d",
                 $time, name, expected, actual);
        mismatches++;
    end
endtask

task automatic csr_write(input csr_addr_t addr, input write_op_t op, input logic src,
                         input csr_word_t value);
    req = '0;
    req.write = 1'b1;
    req.op = op;
    req.src = src;
    req.addr = addr;
    // the unused source holds the complement so a wrong select shows up
    req.rs1_value = (src == src_reg) ? value : ~value;
    req.imm_value = (src == src_imm) ? value : ~value;
    next_cycle();
    req = '0;
endtask

// read_value is sampled mid-cycle away from both edges
task automatic csr_read(input csr_addr_t addr, output csr_word_t value);
    req = '0;
    req.read = 1'b1;
    req.addr = addr;
    @(negedge clk);
    value = read_value;
    next_cycle();
    req = '0;
endtask

task automatic read_check(input string name, input csr_addr_t addr, input csr_word_t expected);
    csr_word_t value;
    csr_read(addr, value);
    check_word(name, expected, value);
endtask

task automatic issue_trap(input logic exception, input logic mret, input cause_t cause,
                          input csr_word_t pc, input logic taken, input csr_word_t target);
    trap = '0;
    trap.exception = exception;
    trap.mret = mret;
    trap.cause = cause;
    trap.pc = pc;
    @(negedge clk);
    check_bit("trap_taken", taken, trap_taken);
    check_word("trap_pc", target, trap_pc);
    next_cycle();
    trap = '0;
endtask

task automatic wait_for_cycle(input logic [counter_w-1:0] target, input int limit);
    int waited;
    waited = 0;
    while (cycle < target && waited < limit) begin
        next_cycle();
        waited++;
    end
    if (cycle < target) begin
        $display("timed out after %0d cycles waiting for the cycle counter to reach %0d",
                 limit, target);
        timeouts++;
    end
endtask

`endif

/* dv/csr_unit_tb.sv */
`default_nettype none

module csr_unit_tb import csr_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic                 clk;
    logic                 reset;
    logic                 stall;
    logic                 flush;
    logic                 writeback_flush;
    csr_req_t             req;
    trap_req_t            trap;
    logic                 instr_retired;
    csr_word_t            read_value;
    logic                 trap_taken;
    csr_word_t            trap_pc;
    logic [counter_w-1:0] cycle;

    integer seed;
    int     checks;
    int     mismatches;
    int     timeouts;

    csr_unit u_dut (
        .clk             (clk),
        .reset           (reset),
        .stall           (stall),
        .flush           (flush),
        .writeback_flush (writeback_flush),
        .req             (req),
        .trap            (trap),
        .instr_retired   (instr_retired),
        .read_value      (read_value),
        .trap_taken      (trap_taken),
        .trap_pc         (trap_pc),
        .cycle           (cycle)
    );

    `include "csr_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // readback of a plain write by the field layout of each register
    function automatic csr_word_t masked_readback(input csr_addr_t addr, input csr_word_t value);
        case (addr)
            csr_mstatus: return (value & 32'h0000_0088) | 32'h0000_1800;
            csr_mie:     return value & 32'h0000_0888;
            csr_mtvec:   return value & ~32'h0000_0002;
            csr_mepc:    return value & ~32'h0000_0003;
            csr_mcause:  return value & 32'h8000_000F;
            default:     return value;
        endcase
    endfunction

    task automatic read_write_masking();
        csr_addr_t addrs[7];
        csr_word_t value;
        addrs = '{csr_mscratch, csr_mtvec, csr_mie, csr_mstatus, csr_mepc, csr_mcause, csr_mtval};
        read_check("mstatus after reset", csr_mstatus, 32'h0000_1800);
        foreach (addrs[i]) begin
            value = $random(seed);
            csr_write(addrs[i], op_rw, (i % 2 == 0) ? src_reg : src_imm, value);
            read_check($sformatf("csr 0x%03h", addrs[i]), addrs[i],
                       masked_readback(addrs[i], value));
        end
        // mxl of 1 with only the I extension bit
        read_check("misa", csr_misa, 32'h4000_0100);
        read_check("unimplemented csr 0x7c0", 12'h7C0, 32'h0);
    endtask

    task automatic set_clear_ops();
        csr_word_t expected;
        csr_word_t operand;
        expected = $random(seed);
        csr_write(csr_mscratch, op_rw, src_reg, expected);
        for (int i = 0; i < 6; i++) begin
            operand = $random(seed);
            if (i % 2 == 0) begin
                csr_write(csr_mscratch, op_rs, src_reg, operand);
                expected = expected | operand;
            end else begin
                csr_write(csr_mscratch, op_rc, src_imm, operand);
                expected = expected & ~operand;
            end
            read_check("mscratch after set or clear", csr_mscratch, expected);
        end
    endtask

    task automatic stall_flush_suppression();
        csr_word_t kept;
        csr_word_t pc_before;
        kept = $random(seed);
        csr_write(csr_mscratch, op_rw, src_reg, kept);
        stall = 1'b1;
        csr_write(csr_mscratch, op_rw, src_reg, ~kept);
        stall = 1'b0;
        read_check("mscratch after stalled write", csr_mscratch, kept);
        flush = 1'b1;
        csr_write(csr_mscratch, op_rw, src_imm, ~kept);
        flush = 1'b0;
        read_check("mscratch after flushed write", csr_mscratch, kept);
        csr_read(csr_mepc, pc_before);
        stall = 1'b1;
        issue_trap(1'b1, 1'b0, cause_ecall_m, ~pc_before, 1'b0, 32'h0);
        stall = 1'b0;
        flush = 1'b1;
        issue_trap(1'b1, 1'b0, cause_breakpoint, ~pc_before, 1'b0, 32'h0);
        flush = 1'b0;
        read_check("mepc after suppressed exceptions", csr_mepc, pc_before);
    endtask

    task automatic exception_entry();
        csr_word_t vector;
        csr_word_t pc;
        cause_t    cause;
        vector = $random(seed);
        pc = $random(seed);
        cause = cause_t'($random(seed));
        csr_write(csr_mtvec, op_rw, src_reg, vector);
        // a write to mepc in the same cycle loses to the exception
        req = '0;
        req.write = 1'b1;
        req.src = src_reg;
        req.op = op_rw;
        req.addr = csr_mepc;
        req.rs1_value = ~pc;
        issue_trap(1'b1, 1'b0, cause, pc, 1'b1, vector & ~32'h3);
        req = '0;
        read_check("mepc after exception", csr_mepc, pc & ~32'h3);
        read_check("mcause after exception", csr_mcause, {28'h0, cause});
        // an mret here would move mpie into mie and set mpie
        csr_write(csr_mstatus, op_rw, src_reg, 32'h0000_0008);
        pc = $random(seed);
        issue_trap(1'b1, 1'b1, cause_illegal_instr, pc, 1'b1, vector & ~32'h3);
        read_check("mstatus after exception with mret", csr_mstatus, 32'h0000_1808);
        read_check("mepc after exception with mret", csr_mepc, pc & ~32'h3);
    endtask

    task automatic trap_return();
        csr_word_t return_pc;
        return_pc = $random(seed) & ~32'h3;
        csr_write(csr_mepc, op_rw, src_imm, return_pc);
        csr_write(csr_mstatus, op_rw, src_reg, 32'h0000_0080);
        read_check("mstatus before mret", csr_mstatus, 32'h0000_1880);
        issue_trap(1'b0, 1'b1, '0, 32'h0, 1'b1, return_pc);
        read_check("mstatus after mret", csr_mstatus, 32'h0000_1888);
    endtask

    task automatic counter_checks();
        csr_word_t            first;
        csr_word_t            second;
        csr_word_t            instret_before;
        logic [counter_w-1:0] count_before;
        int                   cycles_apart;
        int                   retired;
        logic                 flushed;
        cycles_apart = 12;
        csr_read(csr_mcycle, first);
        count_before = cycle;
        // each read already spans one edge
        repeat (cycles_apart - 1) next_cycle();
        csr_read(csr_mcycle, second);
        check_word("mcycle difference", cycles_apart, second - first);
        check_count("cycle difference", cycles_apart, cycle - count_before);
        csr_read(csr_cycle, first);
        read_check("time", csr_time, first + 1);
        csr_read(csr_cycleh, second);
        check_word("cycleh", 32'h0, second);
        read_check("mcycleh", csr_mcycleh, second);
        csr_read(csr_minstret, instret_before);
        retired = 0;
        for (int k = 0; k < 16; k++) begin
            flushed = (k == 2) || (($random(seed) % 3) == 0);
            instr_retired = 1'b1;
            writeback_flush = flushed;
            if (!flushed) begin
                retired++;
            end
            next_cycle();
            instr_retired = 1'b0;
            writeback_flush = 1'b0;
            if (k % 2 == 1) begin
                next_cycle();
            end
        end
        read_check("minstret", csr_minstret, instret_before + retired);
        read_check("instret", csr_instret, instret_before + retired);
        read_check("instreth", csr_instreth, 32'h0);
    endtask

    initial begin
        seed = 68;
        checks = 0;
        mismatches = 0;
        timeouts = 0;
        reset = 1'b1;
        clear_inputs();
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        check_count("cycle after reset", '0, cycle);
        check_bit("trap_taken after reset", 1'b0, trap_taken);
        wait_for_cycle(64'd2, 10);
        read_write_masking();
        set_clear_ops();
        stall_flush_suppression();
        exception_entry();
        trap_return();
        counter_checks();
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
hdl/csr_pkg.sv
hdl/csr_access.sv
hdl/machine_regs.sv
hdl/trap_ctrl.sv
hdl/perf_counters.sv
hdl/csr_unit.sv
dv/csr_unit_tb.sv

/* hdl/csr_access.sv */
`default_nettype none

module csr_access import csr_pkg::*; (
    input  csr_req_t       req,
    input  logic           commit,
    input  machine_state_t state,
    input  counters_t      counters,
    output csr_word_t      read_value,
    output csr_write_t     wr
);

    csr_word_t operand;
    csr_word_t new_value;

    assign operand = (req.src == src_reg) ? req.rs1_value : req.imm_value;

    // anything not implemented here reads zero
    always_comb begin
        case (req.addr)
            csr_mstatus: begin
                read_value = '0;
                read_value[12:11] = 2'b11;
                read_value[7] = state.mstatus_mpie;
                read_value[3] = state.mstatus_mie;
            end
            csr_misa: begin
                read_value = misa_value;
            end
            csr_mie: begin
                read_value = '0;
                read_value[11] = state.mie_meie;
                read_value[7] = state.mie_mtie;
                read_value[3] = state.mie_msie;
            end
            csr_mtvec: begin
                read_value = {state.mtvec_base, 1'b0, state.mtvec_mode};
            end
            csr_mscratch: begin
                read_value = state.mscratch;
            end
            csr_mepc: begin
                read_value = {state.mepc, 2'b00};
            end
            csr_mcause: begin
                read_value = '0;
                read_value[xlen-1] = state.mcause_interrupt;
                read_value[3:0] = state.mcause_code;
            end
            csr_mtval: begin
                read_value = state.mtval;
            end
            // time has no separate source and follows the cycle count
            csr_mcycle, csr_cycle, csr_time: begin
                read_value = counters.cycle[xlen-1:0];
            end
            csr_mcycleh, csr_cycleh, csr_timeh: begin
                read_value = counters.cycle[counter_w-1:xlen];
            end
            csr_minstret, csr_instret: begin
                read_value = counters.instret[xlen-1:0];
            end
            csr_minstreth, csr_instreth: begin
                read_value = counters.instret[counter_w-1:xlen];
            end
            default: begin
                read_value = '0;
            end
        endcase
    end

    // read-modify-write against the current read word
    always_comb begin
        case (req.op)
            op_rs: begin
                new_value = read_value | operand;
            end
            op_rc: begin
                new_value = read_value & ~operand;
            end
            default: begin
                new_value = operand;
            end
        endcase
    end

    always_comb begin
        wr.strobe = req.write && commit;
        wr.addr = req.addr;
        wr.value = new_value;
    end

endmodule

`default_nettype wire

/* hdl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    localparam int xlen = 32;
    localparam int csr_addr_w = 12;
    localparam int counter_w = 64;

    typedef logic [csr_addr_w-1:0] csr_addr_t;
    typedef logic [xlen-1:0] csr_word_t;

    // machine trap setup and handling
    localparam csr_addr_t csr_mstatus  = 12'h300;
    localparam csr_addr_t csr_misa     = 12'h301;
    localparam csr_addr_t csr_mie      = 12'h304;
    localparam csr_addr_t csr_mtvec    = 12'h305;
    localparam csr_addr_t csr_mscratch = 12'h340;
    localparam csr_addr_t csr_mepc     = 12'h341;
    localparam csr_addr_t csr_mcause   = 12'h342;
    localparam csr_addr_t csr_mtval    = 12'h343;

    // machine counters and their user-level aliases
    localparam csr_addr_t csr_mcycle    = 12'hB00;
    localparam csr_addr_t csr_minstret  = 12'hB02;
    localparam csr_addr_t csr_mcycleh   = 12'hB80;
    localparam csr_addr_t csr_minstreth = 12'hB82;
    localparam csr_addr_t csr_cycle     = 12'hC00;
    localparam csr_addr_t csr_time      = 12'hC01;
    localparam csr_addr_t csr_instret   = 12'hC02;
    localparam csr_addr_t csr_cycleh    = 12'hC80;
    localparam csr_addr_t csr_timeh     = 12'hC81;
    localparam csr_addr_t csr_instreth  = 12'hC82;

    // mxl = 1 (32 bit), extension I only
    localparam csr_word_t misa_value = 32'h4000_0100;

    typedef enum logic [1:0] {
        op_rw = 2'b00,
        op_rs = 2'b01,
        op_rc = 2'b10
    } write_op_t;

    localparam logic src_imm = 1'b0;
    localparam logic src_reg = 1'b1;

    typedef logic [3:0] cause_t;

    localparam cause_t cause_instr_misaligned = 4'd0;
    localparam cause_t cause_instr_fault      = 4'd1;
    localparam cause_t cause_illegal_instr    = 4'd2;
    localparam cause_t cause_breakpoint       = 4'd3;
    localparam cause_t cause_load_misaligned  = 4'd4;
    localparam cause_t cause_load_fault       = 4'd5;
    localparam cause_t cause_store_misaligned = 4'd6;
    localparam cause_t cause_store_fault      = 4'd7;
    localparam cause_t cause_ecall_m          = 4'd11;

    typedef struct packed {
        logic      read;
        logic      write;
        logic      src;
        write_op_t op;
        csr_addr_t addr;
        csr_word_t rs1_value;
        csr_word_t imm_value;
    } csr_req_t;

    typedef struct packed {
        logic      exception;
        cause_t    cause;
        logic      mret;
        csr_word_t pc;
    } trap_req_t;

    typedef struct packed {
        logic      strobe;
        csr_addr_t addr;
        csr_word_t value;
    } csr_write_t;

    typedef struct packed {
        logic      exception;
        cause_t    cause;
        logic      mret;
        csr_word_t pc;
    } trap_event_t;

    typedef struct packed {
        logic            mstatus_mie;
        logic            mstatus_mpie;
        logic            mie_meie;
        logic            mie_mtie;
        logic            mie_msie;
        logic [xlen-3:0] mtvec_base;
        logic            mtvec_mode;
        csr_word_t       mscratch;
        csr_word_t       mtval;
        logic [xlen-3:0] mepc;
        logic            mcause_interrupt;
        cause_t          mcause_code;
    } machine_state_t;

    typedef struct packed {
        logic [counter_w-1:0] cycle;
        logic [counter_w-1:0] instret;
    } counters_t;

endpackage

`default_nettype wire

/* hdl/csr_unit.sv */
`default_nettype none

module csr_unit import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 flush,
    input  logic                 writeback_flush,
    input  csr_req_t             req,
    input  trap_req_t            trap,
    input  logic                 instr_retired,
    output csr_word_t            read_value,
    output logic                 trap_taken,
    output csr_word_t            trap_pc,
    output logic [counter_w-1:0] cycle
);

    logic           commit;
    csr_write_t     wr;
    trap_event_t    trap_event;
    machine_state_t state;
    counters_t      counters;

    assign cycle = counters.cycle;

    trap_ctrl u_trap_ctrl (
        .stall      (stall),
        .flush      (flush),
        .trap       (trap),
        .state      (state),
        .commit     (commit),
        .trap_event (trap_event),
        .trap_taken (trap_taken),
        .trap_pc    (trap_pc)
    );

    csr_access u_csr_access (
        .req        (req),
        .commit     (commit),
        .state      (state),
        .counters   (counters),
        .read_value (read_value),
        .wr         (wr)
    );

    machine_regs u_machine_regs (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .trap_event (trap_event),
        .state      (state)
    );

    perf_counters u_perf_counters (
        .clk             (clk),
        .reset           (reset),
        .instr_retired   (instr_retired),
        .writeback_flush (writeback_flush),
        .counters        (counters)
    );

endmodule

`default_nettype wire

/* hdl/machine_regs.sv */
`default_nettype none

module machine_regs import csr_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  csr_write_t     wr,
    input  trap_event_t    trap_event,
    output machine_state_t state
);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= '0;
        end else begin
            // software writes keep only the defined fields
            if (wr.strobe) begin
                case (wr.addr)
                    csr_mstatus: begin
                        state.mstatus_mpie <= wr.value[7];
                        state.mstatus_mie <= wr.value[3];
                    end
                    csr_mie: begin
                        state.mie_meie <= wr.value[11];
                        state.mie_mtie <= wr.value[7];
                        state.mie_msie <= wr.value[3];
                    end
                    csr_mtvec: begin
                        state.mtvec_base <= wr.value[xlen-1:2];
                        state.mtvec_mode <= wr.value[0];
                    end
                    csr_mscratch: begin
                        state.mscratch <= wr.value;
                    end
                    csr_mepc: begin
                        state.mepc <= wr.value[xlen-1:2];
                    end
                    csr_mcause: begin
                        state.mcause_interrupt <= wr.value[xlen-1];
                        state.mcause_code <= wr.value[3:0];
                    end
                    csr_mtval: begin
                        state.mtval <= wr.value;
                    end
                    default: begin
                    end
                endcase
            end

            // trap updates come last so they override a same-cycle write
            if (trap_event.exception) begin
                state.mepc <= trap_event.pc[xlen-1:2];
                state.mcause_interrupt <= 1'b0;
                state.mcause_code <= trap_event.cause;
            end else if (trap_event.mret) begin
                state.mstatus_mie <= state.mstatus_mpie;
                state.mstatus_mpie <= 1'b1;
            end
        end
    end

    // trap_ctrl already orders exception ahead of mret
    assert property (@(posedge clk) disable iff (reset)
        !(trap_event.exception && trap_event.mret))
        else $error("exception and mret events in the same cycle");

endmodule

`default_nettype wire

/* hdl/perf_counters.sv */
`default_nettype none

module perf_counters import csr_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      instr_retired,
    input  logic      writeback_flush,
    output counters_t counters
);

    logic retire;

    // an instruction flushed at writeback never retires
    assign retire = instr_retired && !writeback_flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            counters <= '0;
        end else begin
            counters.cycle <= counters.cycle + 1'b1;
            if (retire) begin
                counters.instret <= counters.instret + 1'b1;
            end
        end
    end

    assert property (@(posedge clk)
        !reset && !$past(reset) |-> counters.cycle == $past(counters.cycle) + 1'b1)
        else $error("cycle counter did not advance by one");

endmodule

`default_nettype wire

/* hdl/trap_ctrl.sv */
`default_nettype none

module trap_ctrl import csr_pkg::*; (
    input  logic           stall,
    input  logic           flush,
    input  trap_req_t      trap,
    input  machine_state_t state,
    output logic           commit,
    output trap_event_t    trap_event,
    output logic           trap_taken,
    output csr_word_t      trap_pc
);

    assign commit = !stall && !flush;

    always_comb begin
        trap_event.exception = commit && trap.exception;
        trap_event.mret = commit && trap.mret && !trap.exception;
        trap_event.cause = trap.cause;
        trap_event.pc = trap.pc;
    end

    // redirect target with the exception first
    always_comb begin
        trap_taken = 1'b0;
        trap_pc = '0;
        if (trap_event.exception) begin
            trap_taken = 1'b1;
            trap_pc = {state.mtvec_base, 2'b00};
        end else if (trap_event.mret) begin
            trap_taken = 1'b1;
            trap_pc = {state.mepc, 2'b00};
        end
    end

endmodule

`default_nettype wire
